// File: logic/lms_pkg.sv
`default_nettype none

package lms_pkg;

    localparam int NUM_TAPS  = 16;                 // filter length
    localparam int TAP_IDX_W = 4;                  // enough for 0..15
    localparam int ERR_W     = 11;                 // error magnitude, unsigned
    localparam int REF_W     = 14;                 // reference sample, unsigned
    localparam int PROD_W    = ERR_W + REF_W;      // full e*ref product, 25 bits
    localparam int WEIGHT_W  = 32;                 // accumulator width, wraps

    // all reference samples of one sweep, tap 0 in the low slice
    typedef logic [NUM_TAPS-1:0][REF_W-1:0] ref_vec_t;

    // the whole weight bank as one vector
    typedef logic [NUM_TAPS-1:0][WEIGHT_W-1:0] weight_vec_t;

    // one tap's work handed from the sequencer to the MAC
    typedef struct packed {
        logic                 valid;               // tap slot carries work
        logic [TAP_IDX_W-1:0] idx;                 // tap being updated
        logic [ERR_W-1:0]     e;                   // snapshot error
        logic [REF_W-1:0]     ref_smp;             // reference of this tap
    } tap_issue_t;

    // one write into the weight bank
    typedef struct packed {
        logic                 valid;               // write enable
        logic [TAP_IDX_W-1:0] idx;                 // target register
        logic [WEIGHT_W-1:0]  weight;              // new weight value
    } weight_wr_t;

    // sweep sequencer FSM
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,                          // waiting for start
        SEQ_ISSUE = 2'd1,                          // one tap per cycle
        SEQ_DRAIN = 2'd2                           // last taps finishing
    } seq_state_t;

endpackage : lms_pkg

`default_nettype wire

// File: logic/lms_seq.sv
`timescale 1ns/1ns
`default_nettype none

module lms_seq
    import lms_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       start,                      // sweep request
    input  logic [ERR_W-1:0] err,                  // live error input
    input  ref_vec_t   refs,                       // live reference samples
    output tap_issue_t issue,                      // current tap to the MAC
    output logic       busy,                       // sweep in progress
    output logic       done                        // one cycle, all weights written
);

    seq_state_t           state;                   // FSM state
    logic [TAP_IDX_W-1:0] tap_idx;                 // tap walked this cycle
    logic                 drain_cnt;               // 0 = first drain cycle, 1 = second
    logic                 accept;                  // start taken this cycle
    logic [ERR_W-1:0]     err_q;                   // error frozen for the sweep
    ref_vec_t             refs_q;                  // references frozen for the sweep

    assign accept = start && !busy;                // starts while busy are dropped

    // snapshot of the operands, later input changes do not reach the sweep
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            err_q  <= err;
            refs_q <= refs;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state     <= SEQ_IDLE;
            tap_idx   <= '0;
            drain_cnt <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;                          // pulse by default
            case (state)
                SEQ_IDLE:
                begin
                    if (accept)
                    begin
                        state   <= SEQ_ISSUE;
                        tap_idx <= '0;             // tap 0 goes out next cycle
                        busy    <= 1'b1;
                    end
                end
                SEQ_ISSUE:
                begin
                    tap_idx <= tap_idx + TAP_IDX_W'(1);  // wraps to 0 after tap 15
                    if (tap_idx == TAP_IDX_W'(NUM_TAPS - 1))
                    begin
                        state     <= SEQ_DRAIN;    // tap 15 still in MAC and bank
                        drain_cnt <= 1'b0;
                    end
                end
                SEQ_DRAIN:
                begin
                    if (!drain_cnt)
                    begin
                        drain_cnt <= 1'b1;
                        busy      <= 1'b0;         // last write lands on this edge
                        done      <= 1'b1;
                    end
                    else if (accept)
                    begin
                        state   <= SEQ_ISSUE;      // back-to-back sweep
                        tap_idx <= '0;
                        busy    <= 1'b1;
                    end
                    else
                    begin
                        state <= SEQ_IDLE;
                    end
                end
                default:
                begin
                    state <= SEQ_IDLE;             // illegal encoding recovery
                end
            endcase
        end
    end

    // issue straight from registers, tap i leaves from edge k+i
    always_comb
    begin
        issue.valid   = (state == SEQ_ISSUE);
        issue.idx     = tap_idx;
        issue.e       = err_q;
        issue.ref_smp = refs_q[tap_idx];           // reference mux
    end

endmodule : lms_seq

`default_nettype wire

// File: logic/lms_mac.sv
`timescale 1ns/1ns
`default_nettype none

module lms_mac
    import lms_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  tap_issue_t  issue,                     // tap from the sequencer
    input  weight_vec_t weights,                   // bank contents, old weights
    output weight_wr_t  wr                         // registered write to the bank
);

    logic [PROD_W-1:0]   prod;                     // e * ref, never overflows
    logic [WEIGHT_W-1:0] old_w;                    // weight of the issued tap
    logic [WEIGHT_W-1:0] new_w;                    // updated weight, mod 2^32

    // both operands unsigned, zero-extend to the product width
    assign prod = {{(PROD_W - ERR_W){1'b0}}, issue.e}
                * {{(PROD_W - REF_W){1'b0}}, issue.ref_smp};

    // the bank write of the previous tap targets another index
    assign old_w = weights[issue.idx];

    assign new_w = old_w + {{(WEIGHT_W - PROD_W){1'b0}}, prod};  // wraps

    // registered write to the bank
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            wr <= '0;
        end
        else
        begin
            wr.valid  <= issue.valid;              // one cycle issue to write
            wr.idx    <= issue.idx;                // payload only meaningful with valid
            wr.weight <= new_w;
        end
    end

endmodule : lms_mac

`default_nettype wire

// File: logic/weight_bank.sv
`timescale 1ns/1ns
`default_nettype none

module weight_bank
    import lms_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  weight_wr_t  wr,                        // single write port
    output weight_vec_t weights                    // all taps, always visible
);

    weight_vec_t bank_q;                           // the 16 weight registers

    // weights start from zero, only reset clears them
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < NUM_TAPS; i++)
            begin
                bank_q[i] <= '0;
            end
        end
        else if (wr.valid)
        begin
            bank_q[wr.idx] <= wr.weight;           // visible one edge later
        end
    end

    assign weights = bank_q;                       // full vector to top and MAC

endmodule : weight_bank

`default_nettype wire

// File: logic/lms_weight_update.sv
`timescale 1ns/1ns
`default_nettype none

module lms_weight_update
    import lms_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    input  logic             start,                // begin one update sweep
    input  logic [ERR_W-1:0] err,                  // error value e
    input  ref_vec_t         refs,                 // 16 reference samples
    output logic             busy,                 // sweep running
    output logic             done,                 // sweep finished, one cycle
    output weight_vec_t      weights               // current tap weights
);

    tap_issue_t  issue;                            // sequencer to MAC
    weight_wr_t  wr;                               // MAC to bank
    weight_vec_t bank_w;                           // bank to MAC and outputs

    // walks taps 0..15, one per cycle
    lms_seq u_seq (
        .clk   (clk),
        .rstn  (rstn),
        .start (start),
        .err   (err),
        .refs  (refs),
        .issue (issue),
        .busy  (busy),
        .done  (done)
    );

    // w[i] + e*ref[i], registered
    lms_mac u_mac (
        .clk     (clk),
        .rstn    (rstn),
        .issue   (issue),
        .weights (bank_w),
        .wr      (wr)
    );

    // weight storage
    weight_bank u_bank (
        .clk     (clk),
        .rstn    (rstn),
        .wr      (wr),
        .weights (bank_w)
    );

    assign weights = bank_w;

endmodule : lms_weight_update

`default_nettype wire

// File: bench/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen
(
    output logic clk,                              // free-running testbench clock
    output logic rstn                              // active low, released on a falling edge
);

    localparam int HALF_PERIOD  = 2;               // 4 ns period
    localparam int RESET_CYCLES = 5;               // rising edges held in reset

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                            // away from the sampling edge
        rstn = 1'b1;
    end

endmodule : tb_clkgen

`default_nettype wire

// File: bench/tb_lms_weight_update.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lms_weight_update
    import lms_pkg::*;
();

    localparam int NUM_ROWS   = 8;                 // rows in the sweep table
    localparam int POKE_CYCLE = 5;                 // when the ignored start goes in
    localparam int DONE_LAT   = 17;                // edges from accepted start to done

    // one table row, reps repeats the same sweep
    typedef struct packed {
        logic [ERR_W-1:0] e;                       // error value of the sweep
        logic             rand_refs;               // 1 = references from the LCG
        logic [REF_W-1:0] ref_const;               // used for all taps when not random
        logic             busy_poke;               // second start while busy
        logic [7:0]       reps;                    // how often the row runs
    } sweep_row_t;

    logic             clk;
    logic             rstn;
    logic             start;
    logic [ERR_W-1:0] err;
    ref_vec_t         refs;
    logic             busy;
    logic             done;
    weight_vec_t      weights;

    sweep_row_t          rows [NUM_ROWS];          // stimulus table
    logic [WEIGHT_W-1:0] model [NUM_TAPS];         // expected weights
    logic [31:0]         lcg_state;                // random generator state
    int                  cycle_cnt = 0;            // watchdog counter
    int                  cycle_limit = 0;

    tb_clkgen u_clkgen (
        .clk  (clk),
        .rstn (rstn)
    );

    lms_weight_update uut (
        .clk     (clk),
        .rstn    (rstn),
        .start   (start),
        .err     (err),
        .refs    (refs),
        .busy    (busy),
        .done    (done),
        .weights (weights)
    );

    // numerical recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
                                  input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // either 16 fresh random samples or one constant for all taps
    task automatic make_refs(input logic use_rand, input logic [REF_W-1:0] c,
                             output ref_vec_t r);
        for (int i = 0; i < NUM_TAPS; i++)
        begin
            if (use_rand)
            begin
                lcg_state = lcg_next(lcg_state);
                r[i]      = lcg_state[29:16];      // upper bits, better spread
            end
            else
            begin
                r[i] = c;
            end
        end
    endtask

    task automatic check_weights(input string what);
        for (int i = 0; i < NUM_TAPS; i++)
        begin
            compare_values(weights[i], model[i], $sformatf("%s, weight %0d", what, i));
        end
    endtask

    // one accepted sweep, entered and left on a falling edge
    task automatic run_sweep(input logic [ERR_W-1:0] e_val, input ref_vec_t r_val,
                             input logic poke);
        int       lat;
        ref_vec_t junk_refs;
        @(negedge clk);
        compare_values(32'(busy), 32'd0, "busy before start");
        err   = e_val;
        refs  = r_val;
        start = 1'b1;
        @(negedge clk);                            // edge k has taken the start
        start = 1'b0;
        lat   = 0;
        compare_values(32'(busy), 32'd1, "busy after accepted start");
        while (!done)
        begin
            @(negedge clk);
            lat++;
            if (poke && lat == POKE_CYCLE)
            begin
                make_refs(1'b1, '0, junk_refs);    // new operands, must be ignored
                err   = ~e_val;
                refs  = junk_refs;
                start = 1'b1;
            end
            else
            begin
                start = 1'b0;
            end
            if (!done)
            begin
                compare_values(32'(busy), 32'd1, "busy during sweep");
            end
        end
        compare_values(32'(lat), 32'(DONE_LAT), "done latency after start");
        compare_values(32'(busy), 32'd0, "busy in done cycle");
        for (int i = 0; i < NUM_TAPS; i++)
        begin
            model[i] = model[i] + 32'(e_val) * 32'(r_val[i]);  // wraps mod 2^32
        end
        check_weights("weights at done");
        @(negedge clk);
        compare_values(32'(done), 32'd0, "done longer than one cycle");
    endtask

    // ends a hung run
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("Timeout: test did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    initial
    begin
        int       total;
        ref_vec_t r;
        start     = 1'b0;
        err       = '0;
        refs      = '0;
        lcg_state = 32'hb4ce_5b04;
        for (int i = 0; i < NUM_TAPS; i++)
        begin
            model[i] = '0;                         // reset value of the bank
        end

        rows[0] = '{e: 11'd37,   rand_refs: 1'b1, ref_const: 14'd0,     busy_poke: 1'b0, reps: 8'd1};
        rows[1] = '{e: 11'd2047, rand_refs: 1'b0, ref_const: 14'd16383, busy_poke: 1'b0, reps: 8'd2};
        rows[2] = '{e: 11'd0,    rand_refs: 1'b1, ref_const: 14'd0,     busy_poke: 1'b0, reps: 8'd1};
        rows[3] = '{e: 11'd1234, rand_refs: 1'b1, ref_const: 14'd0,     busy_poke: 1'b1, reps: 8'd1};
        rows[4] = '{e: 11'd2047, rand_refs: 1'b0, ref_const: 14'd16383, busy_poke: 1'b0, reps: 8'd130};
        rows[5] = '{e: 11'd999,  rand_refs: 1'b1, ref_const: 14'd0,     busy_poke: 1'b0, reps: 8'd2};
        rows[6] = '{e: 11'd0,    rand_refs: 1'b0, ref_const: 14'd16383, busy_poke: 1'b0, reps: 8'd1};
        rows[7] = '{e: 11'd2047, rand_refs: 1'b1, ref_const: 14'd0,     busy_poke: 1'b1, reps: 8'd1};

        total = 0;
        for (int row = 0; row < NUM_ROWS; row++)
        begin
            total += int'(rows[row].reps);
        end
        cycle_limit = total * 20 + 50;             // 20 cycles per sweep plus reset slack

        wait (rstn === 1'b1);
        @(negedge clk);
        compare_values(32'(busy), 32'd0, "busy after reset");
        compare_values(32'(done), 32'd0, "done after reset");
        check_weights("after reset");

        // row 4 alone carries the sums past 2^32
        for (int row = 0; row < NUM_ROWS; row++)
        begin
            for (int rep = 0; rep < int'(rows[row].reps); rep++)
            begin
                make_refs(rows[row].rand_refs, rows[row].ref_const, r);
                run_sweep(rows[row].e, r, rows[row].busy_poke);
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule : tb_lms_weight_update

`default_nettype wire

// File: vlog.f
logic/lms_pkg.sv
logic/lms_seq.sv
logic/lms_mac.sv
logic/weight_bank.sv
logic/lms_weight_update.sv
bench/tb_clkgen.sv
bench/tb_lms_weight_update.sv

// File: Makefile
# Verilator flow for the LMS weight update unit

VERILATOR ?= verilator
TOP       ?= tb_lms_weight_update
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --timing -j 0
BIN       := $(BUILD_DIR)/V$(TOP)

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides, the exit status of the binary is not trusted alone
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
